//--- ifu_mem_pkg.sv
// ------------------------------
// Widths and response code of the instruction memory port.
// Used by the fetch unit and by the memory model.
// ------------------------------
`default_nettype none

package ifu_mem_pkg;

    localparam int xlen        = 32;    // Address and PC width
    localparam int imem_dwidth = 32;    // Memory data width

    typedef enum logic [1:0] {
        resp_not_rdy = 2'b00,           // No response this cycle
        resp_rdy_ok  = 2'b01,
        resp_rdy_er  = 2'b10,           // Access fault
        resp_spare   = 2'b11
    } mem_resp_e;

endpackage

`default_nettype wire

//--- ifu_instr_pkg.sv
// ------------------------------
// Parcel, fetched word and queue control types
// of the fetch datapath.
// ------------------------------
`default_nettype none

package ifu_instr_pkg;

    typedef logic [ifu_mem_pkg::imem_dwidth/2-1:0] parcel_t;

    // A returned word is a whole RV32I instruction or two parcels
    typedef union packed {
        logic [ifu_mem_pkg::imem_dwidth-1:0] word;
        struct packed {
            parcel_t hi;
            parcel_t lo;
        } parcel;
    } fetch_word_u;

    // Named as <upper parcel>_<lower parcel>
    typedef enum logic [2:0] {
        rdata_none,
        rdata_rvi_hi_rvi_lo,                // Whole RV32I instruction
        rdata_rvc_rvc,
        rdata_rvi_lo_rvc,
        rdata_rvc_rvi_hi,
        rdata_rvi_lo_rvi_hi,
        rdata_rvc_nv,                       // Lower parcel skipped
        rdata_rvi_lo_nv
    } rdata_ident_e;

    typedef enum logic [1:0] {we_none, we_hi, we_full} q_we_e;

    typedef enum logic [1:0] {re_none, re_half, re_word} q_re_e;

endpackage

`default_nettype wire

//--- ifu_fetch_ctrl.sv
// ------------------------------
// Idle/fetch state and memory request decision.
// Also marks a start from an unaligned PC.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module ifu_fetch_ctrl #(
    parameter int q_size_word = 2,
    parameter int txn_cnt_w   = 3
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               new_pc_req,
    input  logic                               new_pc_bit1,
    input  logic                               stop_fetch,
    input  logic                               resp_er,
    input  logic                               resp_vd,
    input  logic                               discard,
    input  logic                               txn_full,
    input  logic [txn_cnt_w-1:0]               vd_txns,     // Outstanding, not discarded
    input  logic [$clog2(q_size_word+1)-1:0]   q_free_w,
    output logic                               imem_req,
    output logic                               fetching,
    output logic                               unaligned
);

    logic fetch_st;
    logic fault_stop;

    // A kept fault halts fetch unless a redirect comes with it
    assign fault_stop = resp_er & ~discard & ~new_pc_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_st <= 1'b0;
        end else if (fetch_st) begin
            fetch_st <= ~(stop_fetch | fault_stop);
        end else begin
            fetch_st <= new_pc_req & ~stop_fetch;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            unaligned <= 1'b0;
        end else if (new_pc_req) begin
            unaligned <= new_pc_bit1;
        end else if (resp_vd) begin
            unaligned <= 1'b0;                  // First word consumed
        end
    end

    // Never ask for more words than the queue can take
    assign imem_req = ~txn_full & ((new_pc_req & ~stop_fetch)
                    | (fetch_st & (txn_cnt_w'(q_free_w) > vd_txns)));
    assign fetching = fetch_st;

endmodule

`default_nettype wire

//--- ifu_addr_gen.sv
// ------------------------------
// Word address register and request address select.
// Requests are always word aligned.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module ifu_addr_gen (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          new_pc_req,
    input  logic [ifu_mem_pkg::xlen-1:0]  new_pc,
    input  logic                          imem_req,
    input  logic                          imem_req_ack,
    output logic [ifu_mem_pkg::xlen-1:0]  imem_addr
);

    logic [ifu_mem_pkg::xlen-1:2] addr_r;      // Next word to request
    logic [ifu_mem_pkg::xlen-1:2] word_sel;

    assign word_sel  = new_pc_req ? new_pc[ifu_mem_pkg::xlen-1:2] : addr_r;
    assign imem_addr = {word_sel, 2'b00};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_r <= '0;
        end else if (imem_req & imem_req_ack) begin
            addr_r <= word_sel + 1'b1;
        end else if (new_pc_req) begin
            addr_r <= new_pc[ifu_mem_pkg::xlen-1:2];     // Request not taken yet
        end
    end

endmodule

`default_nettype wire

//--- ifu_txn_tracker.sv
// ------------------------------
// Counts outstanding memory transactions and drops
// responses left over from a redirect or a fault.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module ifu_txn_tracker #(
    parameter int txn_cnt_w = 3
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       imem_req,
    input  logic                       imem_req_ack,
    input  ifu_mem_pkg::mem_resp_e     imem_resp,
    input  logic                       new_pc_req,
    output logic                       resp_ok,
    output logic                       resp_er,
    output logic                       resp_vd,     // Response kept
    output logic                       discard,
    output logic                       txn_full,
    output logic [txn_cnt_w-1:0]       vd_txns
);

    logic                 req_acc;
    logic                 resp_any;
    logic [txn_cnt_w-1:0] txn_cnt;                 // Sent, not yet returned
    logic [txn_cnt_w-1:0] txn_cnt_new;
    logic [txn_cnt_w-1:0] disc_cnt;                // Responses still to drop
    logic [txn_cnt_w-1:0] disc_cnt_new;

    assign req_acc     = imem_req & imem_req_ack;
    assign resp_ok     = (imem_resp == ifu_mem_pkg::resp_rdy_ok);
    assign resp_er     = (imem_resp == ifu_mem_pkg::resp_rdy_er);
    assign resp_any    = resp_ok | resp_er;
    assign discard     = |disc_cnt;
    assign resp_vd     = resp_any & ~discard;
    assign txn_full    = &txn_cnt;
    assign vd_txns     = txn_cnt - disc_cnt;
    assign txn_cnt_new = txn_cnt + txn_cnt_w'(req_acc) - txn_cnt_w'(resp_any);

    always_comb begin
        if (new_pc_req) begin
            disc_cnt_new = txn_cnt_new - txn_cnt_w'(req_acc);  // Older requests only
        end else if (resp_er & ~discard) begin
            disc_cnt_new = txn_cnt_new;
        end else begin
            disc_cnt_new = disc_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txn_cnt  <= '0;
            disc_cnt <= '0;
        end else begin
            txn_cnt <= txn_cnt_new;
            if (new_pc_req | resp_er | (resp_ok & discard)) begin
                disc_cnt <= disc_cnt_new;
            end
        end
    end

endmodule

`default_nettype wire

//--- ifu_parcel_splitter.sv
// ------------------------------
// Classifies each kept response word and picks how
// many of its parcels go into the queue.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module ifu_parcel_splitter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  ifu_instr_pkg::fetch_word_u  imem_rdata,
    input  logic                        resp_ok,
    input  logic                        resp_er,
    input  logic                        resp_vd,
    input  logic                        discard,
    input  logic                        new_pc_req,
    input  logic                        unaligned,
    output ifu_instr_pkg::q_we_e        q_we
);

    ifu_instr_pkg::rdata_ident_e ident;
    logic                        hi_rvi;        // Upper parcel opens an RV32I
    logic                        lo_rvi;
    logic                        rvi_pend;      // RV32I upper half due in next word
    logic                        rvi_pend_next;

    assign hi_rvi = &imem_rdata.parcel.hi[1:0];
    assign lo_rvi = &imem_rdata.parcel.lo[1:0];

    always_comb begin
        ident = ifu_instr_pkg::rdata_none;
        if (resp_ok & ~discard) begin
            if (unaligned) begin
                ident = hi_rvi ? ifu_instr_pkg::rdata_rvi_lo_nv : ifu_instr_pkg::rdata_rvc_nv;
            end else if (rvi_pend) begin
                ident = hi_rvi ? ifu_instr_pkg::rdata_rvi_lo_rvi_hi
                               : ifu_instr_pkg::rdata_rvc_rvi_hi;
            end else if (lo_rvi) begin
                ident = ifu_instr_pkg::rdata_rvi_hi_rvi_lo;
            end else begin
                ident = hi_rvi ? ifu_instr_pkg::rdata_rvi_lo_rvc : ifu_instr_pkg::rdata_rvc_rvc;
            end
        end
    end

    always_comb begin
        q_we = ifu_instr_pkg::we_none;
        if (ident == ifu_instr_pkg::rdata_rvc_nv || ident == ifu_instr_pkg::rdata_rvi_lo_nv) begin
            q_we = ifu_instr_pkg::we_hi;          // Skip parcel below the new PC
        end else if (ident != ifu_instr_pkg::rdata_none) begin
            q_we = ifu_instr_pkg::we_full;
        end else if (resp_er & ~discard) begin
            q_we = ifu_instr_pkg::we_full;        // Fault marks both parcels
        end
    end

    assign rvi_pend_next = (ident == ifu_instr_pkg::rdata_rvi_lo_nv)
                         | (ident == ifu_instr_pkg::rdata_rvi_lo_rvi_hi)
                         | (ident == ifu_instr_pkg::rdata_rvi_lo_rvc);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvi_pend <= 1'b0;
        end else if (new_pc_req) begin
            rvi_pend <= 1'b0;
        end else if (resp_vd) begin
            rvi_pend <= rvi_pend_next;
        end
    end

endmodule

`default_nettype wire

//--- ifu_instr_queue.sv
// ------------------------------
// Halfword instruction queue with a fault bit per parcel.
// The head forms the instruction seen by decode.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module ifu_instr_queue #(
    parameter int q_size_word = 2
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  ifu_instr_pkg::fetch_word_u          imem_rdata,
    input  ifu_instr_pkg::q_we_e                q_we,
    input  logic                                resp_er,
    input  logic                                flush,
    input  logic                                idu_rdy,
    output logic [$clog2(q_size_word+1)-1:0]    q_free_w,
    output logic                                instr_vd,
    output logic [ifu_mem_pkg::imem_dwidth-1:0] instr,
    output logic                                imem_err,
    output logic                                err_rvi_hi
);

    localparam int q_size_half = 2 * q_size_word;
    localparam int adr_w       = $clog2(q_size_half);
    localparam int ptr_w       = adr_w + 1;            // Extra bit tells full from empty
    localparam int free_w_w    = $clog2(q_size_word + 1);

    ifu_instr_pkg::parcel_t q_data [q_size_half];
    logic                   q_err  [q_size_half];
    logic [ptr_w-1:0]       rptr;
    logic [ptr_w-1:0]       rptr_next;
    logic [ptr_w-1:0]       wptr;
    logic [ptr_w-1:0]       ocpd;                      // Parcels held
    logic [ptr_w-1:0]       free_h_next;
    logic [adr_w-1:0]       wa0;
    logic [adr_w-1:0]       wa1;
    ifu_instr_pkg::parcel_t data_head;
    ifu_instr_pkg::parcel_t data_next;
    logic                   err_head;
    logic                   err_next;
    logic                   head_rvi;
    ifu_instr_pkg::q_re_e   q_re;

    // ------------------------------
    // Write side
    // ------------------------------
    assign wa0 = wptr[adr_w-1:0];
    assign wa1 = adr_w'(wptr + 1'b1);

    always_ff @(posedge clk) begin
        if (!flush) begin
            case (q_we)
                ifu_instr_pkg::we_hi: begin
                    q_data[wa0] <= imem_rdata.parcel.hi;
                    q_err[wa0]  <= resp_er;
                end
                ifu_instr_pkg::we_full: begin
                    {q_data[wa1], q_data[wa0]} <= imem_rdata.word;
                    q_err[wa0] <= resp_er;
                    q_err[wa1] <= resp_er;
                end
                default: begin
                end
            endcase
        end
    end

    // ------------------------------
    // Pointers and free space
    // ------------------------------
    always_comb begin
        case (q_re)
            ifu_instr_pkg::re_half: rptr_next = rptr + 1'b1;
            ifu_instr_pkg::re_word: rptr_next = rptr + ptr_w'(2);
            default:                rptr_next = rptr;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rptr <= '0;
            wptr <= '0;
        end else if (flush) begin
            rptr <= '0;
            wptr <= '0;
        end else begin
            rptr <= rptr_next;
            if (q_we == ifu_instr_pkg::we_hi) begin
                wptr <= wptr + 1'b1;
            end else if (q_we == ifu_instr_pkg::we_full) begin
                wptr <= wptr + ptr_w'(2);
            end
        end
    end

    assign ocpd        = wptr - rptr;
    assign free_h_next = ptr_w'(q_size_half) - (wptr - rptr_next);
    assign q_free_w    = free_w_w'(free_h_next >> 1);

    // ------------------------------
    // Decode side
    // ------------------------------
    assign data_head = q_data[rptr[adr_w-1:0]];
    assign data_next = q_data[adr_w'(rptr + 1'b1)];
    assign err_head  = q_err[rptr[adr_w-1:0]];
    assign err_next  = q_err[adr_w'(rptr + 1'b1)];
    assign head_rvi  = &data_head[1:0];

    assign instr = head_rvi ? {data_next, data_head} : ifu_mem_pkg::imem_dwidth'(data_head);

    always_comb begin
        instr_vd   = 1'b0;
        imem_err   = 1'b0;
        err_rvi_hi = 1'b0;
        if (ocpd == ptr_w'(1)) begin
            instr_vd = ~head_rvi | err_head;          // Lone RV32I half waits
            imem_err = err_head;
        end else if (ocpd != '0) begin
            instr_vd   = 1'b1;
            imem_err   = err_head | (head_rvi & err_next);
            err_rvi_hi = ~err_head & head_rvi & err_next;
        end
    end

    always_comb begin
        q_re = ifu_instr_pkg::re_none;
        if (instr_vd & idu_rdy) begin
            q_re = (~head_rvi | err_head) ? ifu_instr_pkg::re_half : ifu_instr_pkg::re_word;
        end
    end

endmodule

`default_nettype wire

//--- ifu_top.sv
// ------------------------------
// Instruction fetch unit top level. Connects memory
// port, redirect control and decode handshake.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module ifu_top #(
    parameter int q_size_word = 2,     // Power of two
    parameter int txn_cnt_w   = 3
) (
    input  logic                                clk,
    input  logic                                rst_n,
    output logic                                imem_req,
    input  logic                                imem_req_ack,
    output logic [ifu_mem_pkg::xlen-1:0]        imem_addr,
    input  logic [ifu_mem_pkg::imem_dwidth-1:0] imem_rdata,
    input  ifu_mem_pkg::mem_resp_e              imem_resp,
    input  logic                                new_pc_req,   // One-cycle redirect
    input  logic [ifu_mem_pkg::xlen-1:0]        new_pc,
    input  logic                                stop_fetch,
    input  logic                                idu_rdy,
    output logic                                instr_vd,
    output logic [ifu_mem_pkg::imem_dwidth-1:0] instr,
    output logic                                imem_err,
    output logic                                err_rvi_hi
);

    logic                               flush;
    logic                               unaligned;
    logic                               resp_ok;
    logic                               resp_er;
    logic                               resp_vd;
    logic                               discard;
    logic                               txn_full;
    logic [txn_cnt_w-1:0]               vd_txns;
    logic [$clog2(q_size_word+1)-1:0]   q_free_w;
    ifu_instr_pkg::q_we_e               q_we;

    assign flush = new_pc_req | stop_fetch;

    ifu_fetch_ctrl #(
        .q_size_word (q_size_word),
        .txn_cnt_w   (txn_cnt_w)
    ) u_fetch_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .new_pc_req  (new_pc_req),
        .new_pc_bit1 (new_pc[1]),
        .stop_fetch  (stop_fetch),
        .resp_er     (resp_er),
        .resp_vd     (resp_vd),
        .discard     (discard),
        .txn_full    (txn_full),
        .vd_txns     (vd_txns),
        .q_free_w    (q_free_w),
        .imem_req    (imem_req),
        .fetching    (),                      // State view only
        .unaligned   (unaligned)
    );

    ifu_addr_gen u_addr_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .new_pc_req   (new_pc_req),
        .new_pc       (new_pc),
        .imem_req     (imem_req),
        .imem_req_ack (imem_req_ack),
        .imem_addr    (imem_addr)
    );

    ifu_txn_tracker #(
        .txn_cnt_w (txn_cnt_w)
    ) u_txn_tracker (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_req     (imem_req),
        .imem_req_ack (imem_req_ack),
        .imem_resp    (imem_resp),
        .new_pc_req   (new_pc_req),
        .resp_ok      (resp_ok),
        .resp_er      (resp_er),
        .resp_vd      (resp_vd),
        .discard      (discard),
        .txn_full     (txn_full),
        .vd_txns      (vd_txns)
    );

    ifu_parcel_splitter u_parcel_splitter (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_rdata (imem_rdata),
        .resp_ok    (resp_ok),
        .resp_er    (resp_er),
        .resp_vd    (resp_vd),
        .discard    (discard),
        .new_pc_req (new_pc_req),
        .unaligned  (unaligned),
        .q_we       (q_we)
    );

    ifu_instr_queue #(
        .q_size_word (q_size_word)
    ) u_instr_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_rdata (imem_rdata),
        .q_we       (q_we),
        .resp_er    (resp_er),
        .flush      (flush),
        .idu_rdy    (idu_rdy),
        .q_free_w   (q_free_w),
        .instr_vd   (instr_vd),
        .instr      (instr),
        .imem_err   (imem_err),
        .err_rvi_hi (err_rvi_hi)
    );

endmodule

`default_nettype wire

//--- tb_ifu.sv
// ------------------------------
// Testbench for the fetch unit. A memory model with
// random latency feeds ifu_top, and every consumed
// instruction is checked against a parcel walk.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_ifu;

    localparam int rst_cycles = 10;

    logic                                clk;
    logic                                rst_n;
    logic                                imem_req;
    logic                                imem_req_ack;
    logic [ifu_mem_pkg::xlen-1:0]        imem_addr;
    logic [ifu_mem_pkg::imem_dwidth-1:0] imem_rdata;
    ifu_mem_pkg::mem_resp_e              imem_resp;
    logic                                new_pc_req;
    logic [ifu_mem_pkg::xlen-1:0]        new_pc;
    logic                                stop_fetch;
    logic                                idu_rdy;
    logic                                instr_vd;
    logic [ifu_mem_pkg::imem_dwidth-1:0] instr;
    logic                                imem_err;
    logic                                err_rvi_hi;

    logic [31:0]                         lfsr_s;
    logic [31:0]                         err_lo;      // Faulted word address range
    logic [31:0]                         err_hi;
    logic [31:0]                         fifo_addr [$];
    int unsigned                         fifo_rdy [$];
    logic [ifu_mem_pkg::imem_dwidth-1:0] exp_instr [$];
    logic                                exp_err [$];
    logic                                exp_hi [$];
    int unsigned                         cyc;
    int unsigned                         limit;
    int unsigned                         tot_parcels;
    logic                                hold_ack;
    logic                                slow_rdy;
    logic                                chk_idle;   // imem_req must stay low
    logic                                chk_novd;   // instr_vd must stay low

    ifu_top #(
        .q_size_word (2),
        .txn_cnt_w   (3)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_req     (imem_req),
        .imem_req_ack (imem_req_ack),
        .imem_addr    (imem_addr),
        .imem_rdata   (imem_rdata),
        .imem_resp    (imem_resp),
        .new_pc_req   (new_pc_req),
        .new_pc       (new_pc),
        .stop_fetch   (stop_fetch),
        .idu_rdy      (idu_rdy),
        .instr_vd     (instr_vd),
        .instr        (instr),
        .imem_err     (imem_err),
        .err_rvi_hi   (err_rvi_hi)
    );

    always #50 clk = ~clk;

    // ------------------------------
    // Random numbers and memory
    // ------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int unsigned rnd(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_s = lfsr_step(lfsr_s);
            v = (v << 1) | lfsr_s[0];
        end
        return v;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] s;
        logic [31:0] w;
        s = 32'h6d35 ^ (addr[31:2] * 32'h9e3779b1);
        if (s == 0) s = 32'h6d35;
        w = 0;
        for (int i = 0; i < 40; i++) begin
            s = lfsr_step(s);
            w = {w[30:0], s[0]};                 // Last 32 bits taken
        end
        return w;
    endfunction

    function automatic logic faulted(input logic [31:0] addr);
        return (addr[31:2] >= err_lo[29:0]) && (addr[31:2] <= err_hi[29:0]);
    endfunction

    function automatic logic [15:0] parcel_at(input logic [31:0] pa);
        logic [31:0] w;
        w = mem_word(pa);
        return pa[1] ? w[31:16] : w[15:0];
    endfunction

    // Expected {rvi, imem_err, err_rvi_hi, instr} at a parcel address
    function automatic logic [34:0] ref_instr(input logic [31:0] pa);
        logic [15:0] p;
        logic        rvi;
        logic        e_lo;
        logic        e_hi;
        p    = parcel_at(pa);
        rvi  = &p[1:0];
        e_lo = faulted(pa);
        e_hi = rvi & faulted(pa + 2);
        if (rvi) return {1'b1, e_lo | e_hi, ~e_lo & e_hi, parcel_at(pa + 2), p};
        return {1'b0, e_lo, 1'b0, 16'h0, p};
    endfunction

    task automatic build_stream(input logic [31:0] pc, input int n);
        logic [31:0] pa;
        logic [34:0] r;
        pa = pc;
        for (int i = 0; i < n; i++) begin
            r = ref_instr(pa);
            exp_instr.push_back(r[31:0]);
            exp_err.push_back(r[33]);
            exp_hi.push_back(r[32]);
            tot_parcels += r[34] ? 2 : 1;
            pa += r[34] ? 4 : 2;
            if (r[33]) break;                    // Stream ends at a fault
        end
        limit = rst_cycles + 8 * tot_parcels + 400;
    endtask

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_instr(input logic [ifu_mem_pkg::imem_dwidth-1:0] got,
                               input logic [ifu_mem_pkg::imem_dwidth-1:0] exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch at %0t: instr got %h expected %h", $time, got, exp));
    endtask

    task automatic check_flags(input logic got_err, input logic got_hi,
                               input logic exp_e, input logic exp_h);
        if (got_err !== exp_e)
            fail_run($sformatf("Mismatch at %0t: imem_err got %b expected %b",
                               $time, got_err, exp_e));
        if (got_hi !== exp_h)
            fail_run($sformatf("Mismatch at %0t: err_rvi_hi got %b expected %b",
                               $time, got_hi, exp_h));
    endtask

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc > limit) fail_run("Timeout: the run took longer than its cycle limit");
        #1;                                      // Memory and decode side drive
        imem_resp  = ifu_mem_pkg::resp_not_rdy;
        imem_rdata = '0;
        if (fifo_addr.size() > 0 && fifo_rdy[0] <= cyc) begin
            imem_rdata = mem_word(fifo_addr[0]);
            imem_resp  = faulted(fifo_addr[0]) ? ifu_mem_pkg::resp_rdy_er
                                               : ifu_mem_pkg::resp_rdy_ok;
            void'(fifo_addr.pop_front());
            void'(fifo_rdy.pop_front());
        end
        imem_req_ack = !hold_ack && fifo_addr.size() < 3 && rnd(2) != 0;
        idu_rdy      = exp_instr.size() > 0 && (slow_rdy ? rnd(3) == 0 : rnd(1) == 1);
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (imem_req && imem_req_ack) begin
                if (imem_addr[1:0] != 2'b00) fail_run("Request address is not word aligned");
                fifo_addr.push_back(imem_addr);
                fifo_rdy.push_back(cyc + 1 + rnd(2));   // 0 to 3 cycles latency
            end
            if (instr_vd && idu_rdy) begin
                if (exp_instr.size() == 0) fail_run("Instruction consumed with none expected");
                check_instr(instr, exp_instr.pop_front());
                check_flags(imem_err, err_rvi_hi, exp_err.pop_front(), exp_hi.pop_front());
            end
            if (chk_idle && imem_req) fail_run("imem_req high while fetch is stopped");
            if (chk_novd && instr_vd) fail_run("Instruction presented after stop");
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic redirect(input logic [31:0] pc, input int n);
        new_pc_req = 1'b1;                       // Called at edge plus 2 ns
        new_pc     = pc;
        idu_rdy    = 1'b0;
        exp_instr.delete();
        exp_err.delete();
        exp_hi.delete();
        build_stream(pc, n);
        @(posedge clk);
        #2 new_pc_req = 1'b0;
    endtask

    task automatic wait_done();
        while (exp_instr.size() > 0) @(posedge clk);
        #2;
    endtask

    task automatic idle_window(input logic novd);
        chk_idle = 1'b1;
        chk_novd = novd;
        repeat (20) @(posedge clk);
        #2;
        chk_idle = 1'b0;
        chk_novd = 1'b0;
    endtask

    initial begin
        clk          = 0;
        rst_n        = 0;
        lfsr_s       = 32'h6d35;
        imem_req_ack = 0;
        imem_rdata   = '0;
        imem_resp    = ifu_mem_pkg::resp_not_rdy;
        new_pc_req   = 0;
        new_pc       = '0;
        stop_fetch   = 0;
        idu_rdy      = 0;
        err_lo       = 32'h1000 >> 2;
        err_hi       = 32'h1004 >> 2;
        cyc          = 0;
        tot_parcels  = 0;
        limit        = rst_cycles + 400;
        hold_ack     = 0;
        slow_rdy     = 0;
        chk_idle     = 0;
        chk_novd     = 0;
        repeat (rst_cycles) @(posedge clk);
        #2 rst_n = 1;
        @(posedge clk);
        #2;
        redirect(32'h0000_0100, 60);             // Aligned start
        wait_done();
        redirect(32'h0000_0302, 40);             // Start on upper parcel
        wait_done();
        redirect(32'h0000_0500, 60);
        do begin
            @(posedge clk);
            #2;
        end while (!(exp_instr.size() <= 48 && fifo_addr.size() > 0));
        redirect(32'h0000_0700, 40);             // Mid-stream redirect
        wait_done();
        slow_rdy = 1;
        redirect(32'h0000_0900, 40);
        wait_done();
        slow_rdy = 0;
        redirect(32'h0000_0fc0, 100);            // Runs into the fault range
        wait_done();
        idle_window(1'b0);
        redirect(32'h0000_0fe2, 100);
        wait_done();
        idle_window(1'b0);
        redirect(32'h0000_0b00, 200);
        while (exp_instr.size() >= 185) begin    // Let part of the stream go through
            @(posedge clk);
            #2;
        end
        hold_ack = 1;
        do begin
            @(posedge clk);
            #2;
        end while (!(fifo_addr.size() == 0 && imem_resp == ifu_mem_pkg::resp_not_rdy));
        stop_fetch   = 1;
        imem_req_ack = 0;
        idu_rdy      = 0;
        exp_instr.delete();
        exp_err.delete();
        exp_hi.delete();
        @(posedge clk);
        #2 stop_fetch = 0;
        hold_ack = 0;
        idle_window(1'b1);
        redirect(32'h0000_0d06, 40);             // Resume after stop
        wait_done();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- ifu.f
ifu_mem_pkg.sv
ifu_instr_pkg.sv
ifu_fetch_ctrl.sv
ifu_addr_gen.sv
ifu_txn_tracker.sv
ifu_parcel_splitter.sv
ifu_instr_queue.sv
ifu_top.sv
tb_ifu.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_ifu -f ifu.f -o tb_ifu > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/tb_ifu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation ended with an error status"
    exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1
